//--- logic/mem_stage_pkg.sv
package mem_stage_pkg;

    // Data and address width
    localparam int XLEN = 32;

    localparam logic [6:0] LOAD_OP  = 7'b0000011;
    localparam logic [6:0] STORE_OP = 7'b0100011;
    localparam logic [6:0] CSR_OP   = 7'b1110011;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_IR = 32'h0000_0013;

    // Access width and sign, from funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Bits 11:7 hold imm[4:0] here instead of rd
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef union packed {
        i_type_t i_view;
        s_type_t s_view;
    } instr_u;

endpackage

//--- logic/data_bus_if.sv
interface data_bus_if #(
    parameter int XLEN = 32
);

    // Request side, owned by the master
    logic            read;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;

    // Response side, owned by the slave
    logic [XLEN-1:0] rdata;
    logic            resp;

    modport master (
        output read, write, addr, wdata,
        input  rdata, resp
    );

    modport slave (
        input  read, write, addr, wdata,
        output rdata, resp
    );

endinterface

//--- logic/exmem_reg.sv
module exmem_reg
    import mem_stage_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            bubble_i,
    input  instr_u          ir_i,
    input  logic [XLEN-1:0] alu_i,
    input  logic [XLEN-1:0] csr_i,
    input  logic [XLEN-1:0] store_data_i,

    input  logic            mem_busy_i,
    input  logic            mem_done_i,

    output instr_u          ir_o,
    output logic [XLEN-1:0] addr_o,
    output logic [XLEN-1:0] store_data_o,
    output logic [XLEN-1:0] result_o,
    output logic            mem_start_o,
    output logic            wb_valid_o,
    output logic            stall_o
);

    instr_u     next_ir;
    logic [6:0] next_op;
    logic       next_is_mem;
    logic       accept;
    logic       wb_q;

    // Bubble replaces the incoming instruction
    assign next_ir     = bubble_i ? instr_u'(NOP_IR) : ir_i;
    assign next_op     = next_ir.i_view.opcode;
    assign next_is_mem = (next_op == LOAD_OP) || (next_op == STORE_OP);

    // Held from the start pulse until the sequencer reaches FINISH
    assign stall_o = mem_start_o | mem_busy_i;
    assign accept  = ~stall_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_o        <= NOP_IR;
            mem_start_o <= 1'b0;
            wb_q        <= 1'b0;
        end else begin
            mem_start_o <= 1'b0;
            wb_q        <= 1'b0;
            if (accept) begin
                ir_o        <= next_ir;
                mem_start_o <= next_is_mem;
                wb_q        <= ~next_is_mem;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result_o     <= (next_op == CSR_OP) ? csr_i : alu_i;
            addr_o       <= alu_i;
            store_data_o <= store_data_i;
        end
    end

    // Non-memory retires one cycle after latching, memory on done
    assign wb_valid_o = wb_q | mem_done_i;

endmodule

//--- logic/unaligned_sequencer.sv
module unaligned_sequencer
    import mem_stage_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       start_i,
    input  instr_u                     ir_i,
    input  logic [XLEN-1:0]            addr_i,
    input  logic [XLEN-1:0]            store_data_i,

    output logic                       busy_o,
    output logic                       done_o,
    output logic [XLEN-1:0]            raw_word_o,
    output logic [$clog2(XLEN/8)-1:0]  offset_o,

    data_bus_if.master                 bus
);

    localparam int NB = XLEN / 8;
    localparam int OW = $clog2(NB);

    localparam logic [2:0] IDLE          = 3'd0;
    localparam logic [2:0] READ_FIRST    = 3'd1;
    localparam logic [2:0] READ_SECOND   = 3'd2;
    localparam logic [2:0] MODIFY_FIRST  = 3'd3;
    localparam logic [2:0] WRITE_FIRST   = 3'd4;
    localparam logic [2:0] MODIFY_SECOND = 3'd5;
    localparam logic [2:0] WRITE_SECOND  = 3'd6;
    localparam logic [2:0] FINISH        = 3'd7;

    logic [2:0]         state;

    logic               is_store_q;
    logic [XLEN-OW-1:0] base_q;
    logic [OW-1:0]      off_q;
    logic [2*NB-1:0]    mask_q;
    logic [2*XLEN-1:0]  sdata_q;
    logic [XLEN-1:0]    word_q;

    logic               start_store;
    logic [2:0]         start_f3;
    logic [OW-1:0]      start_off;
    logic [NB-1:0]      size_mask;
    logic [2*NB-1:0]    start_mask;
    logic               split;
    logic               second_word;
    logic [2*XLEN-1:0]  pair_shifted;

    function automatic logic [XLEN-1:0] insert_bytes(
        input logic [XLEN-1:0] old_word,
        input logic [XLEN-1:0] new_word,
        input logic [NB-1:0]   sel
    );
        logic [XLEN-1:0] res;
        res = old_word;
        for (int i = 0; i < NB; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Store detection through the S layout
    assign start_store = (ir_i.s_view.opcode == STORE_OP);
    assign start_f3    = ir_i.i_view.funct3;
    assign start_off   = addr_i[OW-1:0];

    always_comb begin
        case (start_f3)
            F3_B, F3_BU: size_mask = NB'(1);
            F3_H, F3_HU: size_mask = NB'(3);
            default:     size_mask = '1;
        endcase
    end

    // Byte lanes over two consecutive words
    assign start_mask = {{NB{1'b0}}, size_mask} << start_off;
    assign split      = |mask_q[2*NB-1:NB];

    // Second word on top, shifted down so the access starts at byte 0
    assign pair_shifted = {bus.rdata, word_q} >> {off_q, 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state <= READ_FIRST;
                    end
                end
                READ_FIRST: begin
                    if (bus.resp) begin
                        if (is_store_q) begin
                            state <= MODIFY_FIRST;
                        end else if (split) begin
                            state <= READ_SECOND;
                        end else begin
                            state <= FINISH;
                        end
                    end
                end
                READ_SECOND: begin
                    if (bus.resp) begin
                        state <= is_store_q ? MODIFY_SECOND : FINISH;
                    end
                end
                MODIFY_FIRST:  state <= WRITE_FIRST;
                WRITE_FIRST: begin
                    if (bus.resp) begin
                        state <= split ? READ_SECOND : FINISH;
                    end
                end
                MODIFY_SECOND: state <= WRITE_SECOND;
                WRITE_SECOND: begin
                    if (bus.resp) begin
                        state <= FINISH;
                    end
                end
                default:       state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start_i) begin
                    is_store_q <= start_store;
                    base_q     <= addr_i[XLEN-1:OW];
                    off_q      <= start_off;
                    mask_q     <= start_mask;
                    sdata_q    <= {{XLEN{1'b0}}, store_data_i} << {start_off, 3'b000};
                end
            end
            READ_FIRST: begin
                if (bus.resp) begin
                    word_q     <= bus.rdata;
                    raw_word_o <= bus.rdata;
                    offset_o   <= off_q;
                end
            end
            READ_SECOND: begin
                if (bus.resp) begin
                    word_q     <= bus.rdata;
                    // Already aligned, the formatter must not shift again
                    raw_word_o <= pair_shifted[XLEN-1:0];
                    offset_o   <= '0;
                end
            end
            MODIFY_FIRST: begin
                word_q <= insert_bytes(word_q, sdata_q[XLEN-1:0], mask_q[NB-1:0]);
            end
            MODIFY_SECOND: begin
                word_q <= insert_bytes(word_q, sdata_q[2*XLEN-1:XLEN], mask_q[2*NB-1:NB]);
            end
            default: ;
        endcase
    end

    assign second_word = (state == READ_SECOND) || (state == MODIFY_SECOND) ||
                         (state == WRITE_SECOND);

    assign bus.read  = (state == READ_FIRST) || (state == READ_SECOND);
    assign bus.write = (state == WRITE_FIRST) || (state == WRITE_SECOND);
    assign bus.addr  = {base_q + {{(XLEN-OW-1){1'b0}}, second_word}, {OW{1'b0}}};
    assign bus.wdata = word_q;

    assign busy_o = (state != IDLE) && (state != FINISH);
    assign done_o = (state == FINISH);

endmodule

//--- logic/load_formatter.sv
module load_formatter
    import mem_stage_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]           raw_word_i,
    input  logic [$clog2(XLEN/8)-1:0] offset_i,
    input  logic [2:0]                funct3_i,
    output logic [XLEN-1:0]           data_o
);

    logic [XLEN-1:0] shifted;

    // Offset is zero when the sequencer already merged two words
    assign shifted = raw_word_i >> {offset_i, 3'b000};

    always_comb begin
        case (funct3_i)
            F3_B:    data_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            F3_H:    data_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            F3_BU:   data_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
            F3_HU:   data_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: data_o = shifted;
        endcase
    end

endmodule

//--- logic/data_sram.sv
module data_sram
    import mem_stage_pkg::*;
#(
    parameter int DEPTH_WORDS = 256,
    parameter int RESP_DELAY  = 2
) (
    input  logic       clk,
    input  logic       rst_n,

    data_bus_if.slave  bus
);

    // DEPTH_WORDS is a power of two so the index wraps by truncation
    localparam int AW = $clog2(DEPTH_WORDS);
    localparam int CW = (RESP_DELAY > 0) ? $clog2(RESP_DELAY + 1) : 1;

    logic [XLEN-1:0] mem [DEPTH_WORDS] = '{default: '0};

    logic [CW-1:0]   wait_cnt;
    logic [AW-1:0]   word_idx;
    logic            req;

    assign req      = bus.read | bus.write;
    assign word_idx = bus.addr[AW+1:2];

    // Cycles the current request has been waiting
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (bus.resp) begin
            wait_cnt <= '0;
        end else if (req) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign bus.resp  = req && (wait_cnt == CW'(RESP_DELAY));
    assign bus.rdata = mem[word_idx];

    always_ff @(posedge clk) begin
        if (bus.resp && bus.write) begin
            mem[word_idx] <= bus.wdata;
        end
    end

endmodule

//--- logic/mem_stage_top.sv
module mem_stage_top
    import mem_stage_pkg::*;
#(
    parameter int DEPTH_WORDS = 256,
    parameter int RESP_DELAY  = 2
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            bubble_i,
    input  logic [XLEN-1:0] ir_i,
    input  logic [XLEN-1:0] alu_i,
    input  logic [XLEN-1:0] csr_i,
    input  logic [XLEN-1:0] store_data_i,

    output logic            stall_o,
    output logic            wb_valid_o,
    output logic [XLEN-1:0] result_o,
    output logic [4:0]      rd_o
);

    instr_u                      ex_ir;
    logic [XLEN-1:0]             ex_addr;
    logic [XLEN-1:0]             ex_store_data;
    logic [XLEN-1:0]             ex_result;
    logic                        mem_start;
    logic                        mem_busy;
    logic                        mem_done;
    logic [XLEN-1:0]             raw_word;
    logic [$clog2(XLEN/8)-1:0]   byte_offset;
    logic [XLEN-1:0]             load_data;

    data_bus_if #(.XLEN(XLEN)) dbus ();

    exmem_reg u_exmem_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .bubble_i     (bubble_i),
        .ir_i         (ir_i),
        .alu_i        (alu_i),
        .csr_i        (csr_i),
        .store_data_i (store_data_i),
        .mem_busy_i   (mem_busy),
        .mem_done_i   (mem_done),
        .ir_o         (ex_ir),
        .addr_o       (ex_addr),
        .store_data_o (ex_store_data),
        .result_o     (ex_result),
        .mem_start_o  (mem_start),
        .wb_valid_o   (wb_valid_o),
        .stall_o      (stall_o)
    );

    unaligned_sequencer #(.XLEN(XLEN)) u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (mem_start),
        .ir_i         (ex_ir),
        .addr_i       (ex_addr),
        .store_data_i (ex_store_data),
        .busy_o       (mem_busy),
        .done_o       (mem_done),
        .raw_word_o   (raw_word),
        .offset_o     (byte_offset),
        .bus          (dbus.master)
    );

    load_formatter #(.XLEN(XLEN)) u_formatter (
        .raw_word_i (raw_word),
        .offset_i   (byte_offset),
        .funct3_i   (ex_ir.i_view.funct3),
        .data_o     (load_data)
    );

    data_sram #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .RESP_DELAY  (RESP_DELAY)
    ) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (dbus.slave)
    );

    // Loads return memory data, everything else the latched result
    assign result_o = (ex_ir.i_view.opcode == LOAD_OP) ? load_data : ex_result;
    assign rd_o     = ex_ir.i_view.rd;

endmodule

//--- verif/mem_stage_checker.sv
module mem_stage_checker
    import mem_stage_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            read,
    input logic            write,
    input logic            resp,
    input logic [XLEN-1:0] addr,
    input logic [XLEN-1:0] wdata,
    input logic            wb_valid
);

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(read && write))
        else $error("read and write strobes high in the same cycle");

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        addr[1:0] == 2'b00)
        else $error("bus address %h is not word aligned", addr);

    // Unanswered request keeps strobe, address and data
    request_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((read || write) && !resp) |=>
            $stable(read) && $stable(write) && $stable(addr) && $stable(wdata))
        else $error("bus request changed before its response");

    no_wb_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_valid)
        else $error("writeback valid during reset");

endmodule

bind mem_stage_top mem_stage_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .read     (dbus.read),
    .write    (dbus.write),
    .resp     (dbus.resp),
    .addr     (dbus.addr),
    .wdata    (dbus.wdata),
    .wb_valid (wb_valid_o)
);

//--- verif/mem_stage_tb.sv
module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int    DEPTH_WORDS  = 256;
    localparam int    RESP_DELAY   = 2;
    localparam int    RESET_CYCLES = 5;
    localparam int    DRIVE_DELAY  = 10;
    // Split store: start, read, modify, write, read, modify, write, finish
    localparam int    STORE_CYCLES = 4 * (RESP_DELAY + 1) + 4;
    localparam int    MARGIN       = 20;
    localparam string CASES_FILE   = "verif/mem_stage_cases.txt";

    typedef struct packed {
        logic            bubble;
        logic [XLEN-1:0] ir;
        logic [XLEN-1:0] alu;
        logic [XLEN-1:0] csr;
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] result;
    } case_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            bubble_i;
    logic [XLEN-1:0] ir_i;
    logic [XLEN-1:0] alu_i;
    logic [XLEN-1:0] csr_i;
    logic [XLEN-1:0] store_data_i;
    logic            stall_o;
    logic            wb_valid_o;
    logic [XLEN-1:0] result_o;
    logic [4:0]      rd_o;

    case_t cases[$];
    int    wb_count    = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    mem_stage_top #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .RESP_DELAY  (RESP_DELAY)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .bubble_i     (bubble_i),
        .ir_i         (ir_i),
        .alu_i        (alu_i),
        .csr_i        (csr_i),
        .store_data_i (store_data_i),
        .stall_o      (stall_o),
        .wb_valid_o   (wb_valid_o),
        .result_o     (result_o),
        .rd_o         (rd_o)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Bubbles retire as NOP with rd 0, everything else carries rd in bits 11:7
    function automatic logic [XLEN-1:0] expected_rd(input case_t c);
        return c.bubble ? '0 : XLEN'(c.ir[11:7]);
    endfunction

    // Loads and stores hold the stage right after acceptance
    function automatic logic [XLEN-1:0] expected_stall(input case_t c);
        logic [6:0] op;
        op = c.ir[6:0];
        return XLEN'(!c.bubble && (op == LOAD_OP || op == STORE_OP));
    endfunction

    task automatic load_cases();
        int              fd;
        int              n;
        string           line;
        logic [XLEN-1:0] b;
        case_t           c;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the cases file %s", CASES_FILE);
            $display("Result: FAILED");
            $fatal(1, "missing cases file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h", b, c.ir, c.alu, c.csr, c.store_data, c.result);
            if (n == 6) begin
                c.bubble = b[0];
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_case(input case_t c);
        bubble_i     = c.bubble;
        ir_i         = c.ir;
        alu_i        = c.alu;
        csr_i        = c.csr;
        store_data_i = c.store_data;
    endtask

    initial begin
        rst_n        = 1'b0;
        bubble_i     = 1'b0;
        ir_i         = NOP_IR;
        alu_i        = '0;
        csr_i        = '0;
        store_data_i = '0;
        load_cases();
        cycle_limit = RESET_CYCLES + cases.size() * STORE_CYCLES + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int i = 0; i < cases.size(); i++) begin
            apply_case(cases[i]);
            // Held until an edge with stall_o low takes it
            @(negedge clk);
            while (stall_o) begin
                @(negedge clk);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            check_value("stall_o", XLEN'(stall_o), expected_stall(cases[i]));
        end
        bubble_i = 1'b1;
        alu_i    = '0;
        while (wb_count < cases.size()) begin
            @(posedge clk);
        end
        if (cases.size() > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("No instructions were run, the cases file holds no valid lines");
            $display("Result: FAILED");
            $fatal(1, "empty run");
        end
    end

    // Writebacks must come back in program order
    always @(negedge clk) begin
        if (rst_n && wb_valid_o) begin
            if (wb_count >= cases.size()) begin
                $display("Writeback at %0t with no instruction outstanding", $time);
                $display("Result: FAILED");
                $fatal(1, "extra writeback");
            end else begin
                // Next instruction is taken on the retiring edge
                check_value("stall_o", XLEN'(stall_o), '0);
                check_value("result_o", result_o, cases[wb_count].result);
                check_value("rd_o", XLEN'(rd_o), expected_rd(cases[wb_count]));
                wb_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycle_count, wb_count, cases.size());
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- verif/mem_stage_cases.txt
# bubble ir alu csr store_data expected_result, all hex
# rd is expected from ir bits 11:7, or 0 for a bubble
0 000000b3 11111111 22222222 00000000 11111111
0 00001173 33333333 44444444 00000000 44444444
1 00001173 55555555 66666666 00000000 55555555
0 00002223 00000100 00000000 deadbeef 00000100
0 00000023 00000101 00000000 000000a5 00000101
0 00001023 00000102 00000000 00001234 00000102
0 00000023 00000103 00000000 00000080 00000103
0 00002283 00000100 00000000 00000000 8034a5ef
0 00000303 00000103 00000000 00000000 ffffff80
0 00004383 00000103 00000000 00000000 00000080
0 00001403 00000102 00000000 00000000 ffff8034
0 00005483 00000102 00000000 00000000 00008034
0 00002023 00000201 00000000 aabbccdd 00000201
0 00002023 00000206 00000000 11223344 00000206
0 00002283 00000201 00000000 00000000 aabbccdd
0 00002503 00000206 00000000 00000000 11223344
0 00001583 00000203 00000000 00000000 ffffaabb
0 00002283 00000200 00000000 00000000 bbccdd00
0 00002283 00000204 00000000 00000000 334400aa
0 000000b3 99999999 00000000 00000000 99999999
0 00002023 0000010b 00000000 01020304 0000010b
0 00002503 0000010b 00000000 00000000 01020304
0 00002503 0000010c 00000000 00000000 00010203
0 00001173 00000000 abcdef01 00000000 abcdef01

//--- mem_stage.f
logic/mem_stage_pkg.sv
logic/data_bus_if.sv
logic/exmem_reg.sv
logic/unaligned_sequencer.sv
logic/load_formatter.sv
logic/data_sram.sv
logic/mem_stage_top.sv
verif/mem_stage_checker.sv
verif/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
